/* Makefile */
# Verilator build and run for the rvseed core testbench

VERILATOR ?= verilator
TOP       ?= tb_rvseed_core
FILELIST  ?= rvseed_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?=
VFLAGS    ?= --binary --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "sim passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* alu.sv */
`timescale 1ns/1ns

module alu (
    input  rvseed_pkg::xlen_t    rdata1,
    input  rvseed_pkg::xlen_t    rdata2,
    input  rvseed_pkg::xlen_t    pc,
    input  rvseed_pkg::xlen_t    imm,
    input  rvseed_pkg::alu_src_e alu_src,
    input  rvseed_pkg::alu_op_e  alu_op,
    output rvseed_pkg::xlen_t    result,
    output logic                 zero
);
    import rvseed_pkg::*;

    xlen_t op_a;
    xlen_t op_b;

    always_comb begin
        case (alu_src)
            SRC_REG_IMM: begin
                op_a = rdata1;
                op_b = imm;
            end
            SRC_PC_IMM: begin
                op_a = pc;
                op_b = imm;
            end
            SRC_PC_FOUR: begin
                op_a = pc;
                op_b = 64'd4;  // link value
            end
            default: begin
                op_a = rdata1;
                op_b = rdata2;
            end
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            default: result = op_a + op_b;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* ctrl.sv */
`timescale 1ns/1ns

module ctrl (
    input  rvseed_pkg::inst_t     inst,
    output logic                  branch,
    output logic                  jump,
    output logic                  jalr,
    output logic                  reg_wen,
    output rvseed_pkg::reg_addr_t reg_waddr,
    output rvseed_pkg::reg_addr_t reg1_raddr,
    output rvseed_pkg::reg_addr_t reg2_raddr,
    output rvseed_pkg::imm_op_e   imm_op,
    output rvseed_pkg::alu_op_e   alu_op,
    output rvseed_pkg::alu_src_e  alu_src,
    output logic                  mem_read,
    output logic                  mem_write,
    output rvseed_pkg::wmask_t    wmask,
    output logic                  halt_req,
    output logic                  illegal
);
    import rvseed_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        branch     = 1'b0;
        jump       = 1'b0;
        jalr       = 1'b0;
        reg_wen    = 1'b0;
        reg_waddr  = '0;
        reg1_raddr = '0;  // x0 unless an rs1 is used
        reg2_raddr = '0;
        imm_op     = IMM_I;
        alu_op     = ALU_AND;
        alu_src    = SRC_REG_REG;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        wmask      = '0;
        halt_req   = 1'b0;
        illegal    = 1'b0;
        case (opcode)
            OP_R: begin
                if (funct3 == F3_ADD_SUB && (funct7 == F7_ADD || funct7 == F7_SUB)) begin
                    reg_wen    = 1'b1;
                    reg_waddr  = rd;
                    reg1_raddr = rs1;
                    reg2_raddr = rs2;
                    alu_op     = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                end else begin
                    illegal = 1'b1;
                end
            end
            OP_I: begin
                if (funct3 == F3_ADDI) begin
                    reg_wen    = 1'b1;
                    reg_waddr  = rd;
                    reg1_raddr = rs1;
                    alu_op     = ALU_ADD;
                    alu_src    = SRC_REG_IMM;
                end else begin
                    illegal = 1'b1;
                end
            end
            OP_LOAD: begin
                if (funct3 == F3_LW) begin
                    reg_wen    = 1'b1;
                    reg_waddr  = rd;
                    reg1_raddr = rs1;
                    alu_op     = ALU_ADD;  // rs1 + offset
                    alu_src    = SRC_REG_IMM;
                    mem_read   = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            OP_STORE: begin
                if (funct3 == F3_SD) begin
                    reg1_raddr = rs1;
                    reg2_raddr = rs2;  // store data
                    imm_op     = IMM_S;
                    alu_op     = ALU_ADD;
                    alu_src    = SRC_REG_IMM;
                    mem_write  = 1'b1;
                    wmask      = '1;
                end else begin
                    illegal = 1'b1;
                end
            end
            OP_B: begin
                if (funct3 == F3_BNE) begin
                    branch     = 1'b1;
                    reg1_raddr = rs1;
                    reg2_raddr = rs2;
                    imm_op     = IMM_B;
                    alu_op     = ALU_SUB;  // zero flag compares
                end else begin
                    illegal = 1'b1;
                end
            end
            OP_JAL: begin
                jump      = 1'b1;
                reg_wen   = 1'b1;
                reg_waddr = rd;
                imm_op    = IMM_J;
                alu_op    = ALU_ADD;
                alu_src   = SRC_PC_FOUR;
            end
            OP_JALR: begin
                if (funct3 == F3_JALR) begin
                    jump       = 1'b1;
                    jalr       = 1'b1;
                    reg_wen    = 1'b1;
                    reg_waddr  = rd;
                    reg1_raddr = rs1;  // target base
                    alu_op     = ALU_ADD;
                    alu_src    = SRC_PC_FOUR;
                end else begin
                    illegal = 1'b1;
                end
            end
            OP_LUI: begin
                reg_wen   = 1'b1;
                reg_waddr = rd;
                imm_op    = IMM_U;
                alu_op    = ALU_ADD;
                alu_src   = SRC_REG_IMM;  // x0 + imm
            end
            OP_AUIPC: begin
                reg_wen   = 1'b1;
                reg_waddr = rd;
                imm_op    = IMM_U;
                alu_op    = ALU_ADD;
                alu_src   = SRC_PC_IMM;
            end
            default: begin
                if (inst == INST_EBREAK) begin
                    halt_req = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
        endcase
    end

    always_comb begin
        assert (!(reg_wen && mem_write));
    end

endmodule

/* imm_gen.sv */
`timescale 1ns/1ns

module imm_gen (
    input  rvseed_pkg::inst_t   inst,
    input  rvseed_pkg::imm_op_e imm_op,
    output rvseed_pkg::xlen_t   imm
);
    import rvseed_pkg::*;

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_op)
            IMM_S: begin
                imm = {{52{sign}}, inst[31:25], inst[11:7]};
            end
            IMM_B: begin
                imm = {{52{sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};  // bit 12 is the sign
            end
            IMM_J: begin
                imm = {{44{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            IMM_U: begin
                imm = {{32{sign}}, inst[31:12], 12'b0};
            end
            default: begin
                imm = {{52{sign}}, inst[31:20]};  // I format
            end
        endcase
    end

endmodule

/* pc_reg.sv */
`timescale 1ns/1ns

module pc_reg #(
    parameter rvseed_pkg::xlen_t RESET_PC = rvseed_pkg::RESET_PC
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              branch,
    input  logic              jump,
    input  logic              jalr,
    input  logic              zero,
    input  logic              halt_req,
    input  rvseed_pkg::xlen_t imm,
    input  rvseed_pkg::xlen_t result,
    output rvseed_pkg::xlen_t pc,
    output logic              halt
);
    import rvseed_pkg::*;

    xlen_t pc_next;
    logic  halt_q;  // sticky after ebreak

    assign halt = halt_q || halt_req;

    always_comb begin
        if (jalr) begin
            pc_next = {result[63:1], 1'b0};
        end else if (jump || (branch && !zero)) begin
            pc_next = pc + imm;  // jal or taken bne
        end else begin
            pc_next = pc + 64'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= RESET_PC;
            halt_q <= 1'b0;
        end else begin
            halt_q <= halt;
            if (!halt) begin
                pc <= pc_next;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) halt |=> $stable(pc) && halt);

endmodule

/* regfile.sv */
`timescale 1ns/1ns

module regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wen,
    input  rvseed_pkg::reg_addr_t waddr,
    input  rvseed_pkg::xlen_t     wdata,
    input  rvseed_pkg::reg_addr_t raddr1,
    input  rvseed_pkg::reg_addr_t raddr2,
    output rvseed_pkg::xlen_t     rdata1,
    output rvseed_pkg::xlen_t     rdata2
);
    import rvseed_pkg::*;

    xlen_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin  // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

/* rvseed_core.f */
rvseed_pkg.sv
ctrl.sv
imm_gen.sv
pc_reg.sv
regfile.sv
alu.sv
rvseed_core.sv
tb_rvseed_core.sv

/* rvseed_core.sv */
`timescale 1ns/1ns

module rvseed_core #(
    parameter rvseed_pkg::xlen_t RESET_PC = rvseed_pkg::RESET_PC
) (
    input  logic               clk,
    input  logic               rst_n,
    input  rvseed_pkg::inst_t  inst,
    input  rvseed_pkg::xlen_t  dmem_rdata,
    output rvseed_pkg::xlen_t  pc,
    output rvseed_pkg::xlen_t  dmem_addr,
    output logic               dmem_wen,
    output rvseed_pkg::xlen_t  dmem_wdata,
    output rvseed_pkg::wmask_t dmem_wmask,
    output logic               halt,
    output logic               illegal
);
    import rvseed_pkg::*;

    logic      branch;
    logic      jump;
    logic      jalr;
    logic      reg_wen;
    logic      mem_read;
    logic      mem_write;
    logic      halt_req;
    logic      zero;
    reg_addr_t reg_waddr;
    reg_addr_t reg1_raddr;
    reg_addr_t reg2_raddr;
    imm_op_e   imm_op;
    alu_op_e   alu_op;
    alu_src_e  alu_src;
    wmask_t    wmask;
    xlen_t     imm;
    xlen_t     rdata1;
    xlen_t     rdata2;
    xlen_t     alu_result;
    xlen_t     jalr_target;
    xlen_t     load_data;
    xlen_t     wb_data;

    ctrl ctrl_i (
        .inst       (inst),
        .branch     (branch),
        .jump       (jump),
        .jalr       (jalr),
        .reg_wen    (reg_wen),
        .reg_waddr  (reg_waddr),
        .reg1_raddr (reg1_raddr),
        .reg2_raddr (reg2_raddr),
        .imm_op     (imm_op),
        .alu_op     (alu_op),
        .alu_src    (alu_src),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .wmask      (wmask),
        .halt_req   (halt_req),
        .illegal    (illegal)
    );

    imm_gen imm_gen_i (
        .inst   (inst),
        .imm_op (imm_op),
        .imm    (imm)
    );

    regfile regfile_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wen    (reg_wen && !halt),
        .waddr  (reg_waddr),
        .wdata  (wb_data),
        .raddr1 (reg1_raddr),
        .raddr2 (reg2_raddr),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    alu alu_i (
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .pc      (pc),
        .imm     (imm),
        .alu_src (alu_src),
        .alu_op  (alu_op),
        .result  (alu_result),
        .zero    (zero)
    );

    // alu is busy with the link value during jalr
    assign jalr_target = rdata1 + imm;

    pc_reg #(
        .RESET_PC (RESET_PC)
    ) pc_reg_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .branch   (branch),
        .jump     (jump),
        .jalr     (jalr),
        .zero     (zero),
        .halt_req (halt_req),
        .imm      (imm),
        .result   (jalr_target),
        .pc       (pc),
        .halt     (halt)
    );

    assign load_data = {{32{dmem_rdata[31]}}, dmem_rdata[31:0]};  // lw sign extension
    assign wb_data   = mem_read ? load_data : alu_result;

    assign dmem_addr  = alu_result;
    assign dmem_wen   = mem_write && !halt;
    assign dmem_wdata = rdata2;
    assign dmem_wmask = wmask;

endmodule

/* rvseed_pkg.sv */
package rvseed_pkg;

    typedef logic [63:0] xlen_t;     // data and address word
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  wmask_t;    // one bit per byte

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_J,
        IMM_U
    } imm_op_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG_REG,  // rs1, rs2
        SRC_REG_IMM,  // rs1, imm
        SRC_PC_IMM,   // pc, imm
        SRC_PC_FOUR   // pc, 4 for the link value
    } alu_src_e;

    localparam logic [6:0] OP_R     = 7'b0110011;
    localparam logic [6:0] OP_I     = 7'b0010011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_B     = 7'b1100011;
    localparam logic [6:0] OP_JAL   = 7'b1101111;
    localparam logic [6:0] OP_JALR  = 7'b1100111;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_ADDI    = 3'b000;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SD      = 3'b011;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_JALR    = 3'b000;

    localparam logic [6:0] F7_ADD = 7'b0000000;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    localparam inst_t INST_EBREAK = 32'h0010_0073;

    localparam xlen_t RESET_PC = 64'h8000_0000;

endpackage

/* tb_rvseed_core.sv */
`timescale 1ns/1ns

module tb_rvseed_core;
    import rvseed_pkg::*;

    localparam int PERIOD    = 8;
    localparam int ROM_WORDS = 32;
    localparam int SEQ_LEN   = 24;

    logic   clk = 1'b0;
    logic   rst_n;
    inst_t  inst;
    xlen_t  dmem_rdata;
    xlen_t  pc;
    xlen_t  dmem_addr;
    logic   dmem_wen;
    xlen_t  dmem_wdata;
    wmask_t dmem_wmask;
    logic   halt;
    logic   illegal;

    inst_t rom [ROM_WORDS];
    xlen_t ram [128];
    xlen_t exp_addr [$];
    xlen_t exp_data [$];
    string exp_name [$];
    xlen_t exp_pc;
    int    step;
    int    stores;
    int    errors;
    // word index of every executed instruction, in order
    int    seq [SEQ_LEN] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13,
                             15, 18, 19, 20, 25, 26, 27, 28, 29, 30};

    rvseed_core #(
        .RESET_PC (RESET_PC)
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .dmem_rdata (dmem_rdata),
        .pc         (pc),
        .dmem_addr  (dmem_addr),
        .dmem_wen   (dmem_wen),
        .dmem_wdata (dmem_wdata),
        .dmem_wmask (dmem_wmask),
        .halt       (halt),
        .illegal    (illegal)
    );

    always #(PERIOD / 2) clk = ~clk;

    assign dmem_rdata = ram[dmem_addr[9:3]];

    always @(posedge clk) begin
        if (dmem_wen) begin
            for (int b = 0; b < 8; b++) begin
                if (dmem_wmask[b]) begin
                    ram[dmem_addr[9:3]][b*8 +: 8] <= dmem_wdata[b*8 +: 8];
                end
            end
        end
    end

    function automatic inst_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     reg_addr_t rd);
        return {f7, rs2, rs1, F3_ADD_SUB, rd, OP_R};
    endfunction

    function automatic inst_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, F3_SD, imm[4:0], OP_STORE};
    endfunction

    function automatic inst_t b_type(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[12], imm[10:5], rs2, rs1, F3_BNE, imm[4:1], imm[11], OP_B};
    endfunction

    function automatic inst_t j_type(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic inst_t u_type(logic [19:0] imm, reg_addr_t rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic xlen_t sext32(logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    function automatic xlen_t pc_of(int idx);
        return RESET_PC + xlen_t'(idx) * 64'd4;
    endfunction

    function automatic inst_t fetch(xlen_t addr);
        xlen_t offset;
        offset = addr - RESET_PC;
        if ((offset >> 2) < xlen_t'(ROM_WORDS)) begin
            return rom[offset[6:2]];
        end
        return '0;
    endfunction

    task automatic expect_store(string name, xlen_t addr, xlen_t data);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic report_mismatch(string name, xlen_t expected, xlen_t actual);
        $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        errors++;
    endtask

    task automatic load_program();
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = s_type(12'h000, 5'd1, 5'd0);  // trap store on skipped slots
        end
        rom[0]  = i_type(12'h100, 5'd0, F3_LW, 5'd1, OP_LOAD);
        rom[1]  = i_type(12'h108, 5'd0, F3_LW, 5'd2, OP_LOAD);
        rom[2]  = r_type(F7_ADD, 5'd2, 5'd1, 5'd3);
        rom[3]  = r_type(F7_SUB, 5'd2, 5'd1, 5'd4);
        rom[4]  = i_type(12'hffb, 5'd1, F3_ADDI, 5'd5, OP_I);  // -5
        rom[5]  = s_type(12'h200, 5'd3, 5'd0);
        rom[6]  = s_type(12'h208, 5'd4, 5'd0);
        rom[7]  = s_type(12'h210, 5'd5, 5'd0);
        rom[8]  = u_type(20'h80001, 5'd6, OP_LUI);
        rom[9]  = u_type(20'h7ff00, 5'd7, OP_AUIPC);
        rom[10] = s_type(12'h218, 5'd6, 5'd0);
        rom[11] = s_type(12'h220, 5'd7, 5'd0);
        rom[12] = b_type(13'd12, 5'd1, 5'd1);  // equal, falls through
        rom[13] = b_type(13'd8, 5'd0, 5'd6);   // taken over slot 14
        rom[15] = j_type(21'd12, 5'd8);
        rom[18] = s_type(12'h228, 5'd8, 5'd0);
        rom[19] = u_type(20'h00000, 5'd9, OP_AUIPC);
        rom[20] = i_type(12'd25, 5'd9, F3_JALR, 5'd10, OP_JALR);  // odd target
        rom[25] = s_type(12'h230, 5'd10, 5'd0);
        rom[26] = i_type(12'd7, 5'd1, F3_ADDI, 5'd0, OP_I);
        rom[27] = s_type(12'h238, 5'd0, 5'd0);
        rom[28] = 32'hffff_ffff;
        rom[29] = s_type(12'h240, 5'd1, 5'd0);
        rom[30] = INST_EBREAK;
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            exp_pc = (step < SEQ_LEN) ? pc_of(seq[step]) : pc_of(30);  // holds on ebreak
            assert (pc == exp_pc) else report_mismatch("pc_flow", exp_pc, pc);
            assert (illegal == (pc == pc_of(28)))
                else report_mismatch("illegal", xlen_t'(pc == pc_of(28)), xlen_t'(illegal));
            assert (halt == (pc == pc_of(30)))
                else report_mismatch("halt", xlen_t'(pc == pc_of(30)), xlen_t'(halt));
            if (dmem_wen) begin
                if (stores < exp_addr.size()) begin
                    assert (dmem_addr == exp_addr[stores]) else report_mismatch(
                        $sformatf("%s addr", exp_name[stores]), exp_addr[stores], dmem_addr);
                    assert (dmem_wdata == exp_data[stores]) else report_mismatch(
                        $sformatf("%s data", exp_name[stores]), exp_data[stores], dmem_wdata);
                    assert (dmem_wmask == 8'hff) else report_mismatch(
                        $sformatf("%s mask", exp_name[stores]), 64'hff, xlen_t'(dmem_wmask));
                    stores++;
                end else begin
                    $display("store to %h seen after the last expected store", dmem_addr);
                    errors++;
                end
            end
            step++;
        end
    end

    initial begin
        #(ROM_WORDS * 4 * PERIOD);
        $display("watchdog expired, the core never reached its halt");
        $display("sim failed");
        $finish;
    end

    initial begin
        xlen_t word_a;
        xlen_t word_b;
        xlen_t a;
        xlen_t b;
        rst_n = 1'b0;
        inst  = '0;
        void'($urandom(32'hba31));
        load_program();
        for (int i = 0; i < 128; i++) begin
            ram[i] <= 64'h5a5a_5a5a_0000_0000 | xlen_t'(i * 8);
        end
        word_a = {$urandom, $urandom};
        word_b = {$urandom, $urandom};
        word_a[31] = 1'b1;  // negative low word
        ram[32] <= word_a;  // 0x100
        ram[33] <= word_b;  // 0x108
        a = sext32(word_a[31:0]);
        b = sext32(word_b[31:0]);
        expect_store("add", 64'h200, a + b);
        expect_store("sub", 64'h208, a - b);
        expect_store("addi", 64'h210, a - 64'd5);
        expect_store("lui", 64'h218, sext32(32'h8000_1000));
        expect_store("auipc", 64'h220, pc_of(9) + sext32(32'h7ff0_0000));
        expect_store("jal_link", 64'h228, pc_of(15) + 64'd4);
        expect_store("jalr_link", 64'h230, pc_of(20) + 64'd4);
        expect_store("x0_write", 64'h238, 64'd0);
        expect_store("after_illegal", 64'h240, a);
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        inst  = fetch(pc);
        @(negedge clk);
        while (!halt) begin
            @(posedge clk);
            #1;
            inst = fetch(pc);
            @(negedge clk);
        end
        repeat (4) begin  // pc must hold and no store may follow
            @(posedge clk);
            #1;
            inst = fetch(pc);
        end
        @(negedge clk);
        #1;
        if (stores != exp_addr.size()) begin
            $display("only %0d of %0d expected stores were seen", stores, exp_addr.size());
            errors++;
        end
        $display("errors: %0d, stores: %0d of %0d", errors, stores, exp_addr.size());
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
